//--- memIoPkg.sv
package memIoPkg;

    ////////////////////
    // Widths
    ////////////////////
    localparam int dataWidth      = 32;
    localparam int ledWidth       = 8;
    localparam int switchWidth    = 8;
    localparam int tubeWidth      = 18;
    localparam int wordIndexWidth = 8;

    localparam int segDigitWidth = 7;
    localparam int segDigits     = 3;
    localparam int segCodeWidth  = segDigits * segDigitWidth; // 21 significant bits.

    ////////////////////
    // Address map
    ////////////////////
    localparam logic [15:0] ioPage = 16'h4000;

    localparam logic [15:0] timerReloadOffset  = 16'h0000;
    localparam logic [15:0] timerCountOffset   = 16'h0004;
    localparam logic [15:0] timerControlOffset = 16'h0008;
    localparam logic [15:0] ledOffset          = 16'h000C;
    localparam logic [15:0] switchOffset       = 16'h0010;
    localparam logic [15:0] tubeOffset         = 16'h0014;

    localparam logic [dataWidth-1:0] segWindowBase  = 32'h0000_0400;
    localparam logic [dataWidth-1:0] segWindowLimit = 32'h0000_0800; // One past the end.

    typedef struct packed {
        logic                      ram;
        logic                      segTable;
        logic                      timerReload;
        logic                      timerCount;
        logic                      timerControl;
        logic                      led;
        logic                      switchIn;
        logic                      tube;
        logic [wordIndexWidth-1:0] wordIndex;
    } accessSel_t;

    typedef union packed {
        struct packed {
            logic [21:0]               pad;
            logic [wordIndexWidth-1:0] wordIndex;
            logic [1:0]                byteOffset;
        } ramView;
        struct packed {
            logic [15:0] page;
            logic [15:0] offset;
        } ioView;
    } busAddr_u;

endpackage

//--- busDecoder.sv
`timescale 1ns/10ps

module busDecoder import memIoPkg::*; #(
    parameter int ramDepth = 256
) (
    input  logic [dataWidth-1:0] address,
    output accessSel_t           sel
);

    localparam logic [dataWidth-1:0] ramLimit = dataWidth'(ramDepth * 4);

    busAddr_u busAddr;

    assign busAddr = address;

    always_comb begin
        sel           = '0;
        sel.wordIndex = busAddr.ramView.wordIndex; // Shared by RAM and lookup window.
        if (busAddr.ioView.page == ioPage) begin
            case (busAddr.ioView.offset)
                timerReloadOffset:  sel.timerReload  = 1'b1;
                timerCountOffset:   sel.timerCount   = 1'b1;
                timerControlOffset: sel.timerControl = 1'b1;
                ledOffset:          sel.led          = 1'b1;
                switchOffset:       sel.switchIn     = 1'b1;
                tubeOffset:         sel.tube         = 1'b1;
                default:            sel.ram          = 1'b0; // Unmapped offset.
            endcase
        end else if (address >= segWindowBase && address < segWindowLimit) begin
            sel.segTable = 1'b1;
        end else if (address < segWindowBase && address < ramLimit) begin
            sel.ram = 1'b1;
        end
    end

endmodule

//--- dataRam.sv
`timescale 1ns/10ps

module dataRam import memIoPkg::*; #(
    parameter int ramDepth = 256
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 writeEnable,
    input  accessSel_t           sel,
    input  logic [dataWidth-1:0] writeData,
    output logic [dataWidth-1:0] ramWord
);

    localparam int indexWidth = $clog2(ramDepth);

    logic [dataWidth-1:0]  mem [ramDepth];
    logic [indexWidth-1:0] index;

    assign index = sel.wordIndex[indexWidth-1:0];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < ramDepth; i++) begin
                mem[i] <= '0; // Whole array clears.
            end
        end else if (writeEnable && sel.ram) begin
            mem[index] <= writeData;
        end
    end

    assign ramWord = mem[index];

endmodule

//--- ioRegisters.sv
`timescale 1ns/10ps

module ioRegisters import memIoPkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   writeEnable,
    input  accessSel_t             sel,
    input  logic [dataWidth-1:0]   writeData,
    input  logic [switchWidth-1:0] switch,
    output logic [ledWidth-1:0]    led,
    output logic [tubeWidth-1:0]   tube,
    output logic [switchWidth-1:0] switchWord
);

    ////////////////////
    // Output registers
    ////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            led  <= '0;
            tube <= '0;
        end else if (writeEnable) begin
            if (sel.led) begin
                led <= writeData[ledWidth-1:0]; // Low bits only.
            end
            if (sel.tube) begin
                tube <= writeData[tubeWidth-1:0];
            end
        end
    end

    ////////////////////
    // Switch input
    ////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            switchWord <= '0;
        end else begin
            switchWord <= switch; // One cycle behind the pins.
        end
    end

endmodule

//--- intervalTimer.sv
`timescale 1ns/10ps

module intervalTimer import memIoPkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 writeEnable,
    input  accessSel_t           sel,
    input  logic [dataWidth-1:0] writeData,
    output logic [dataWidth-1:0] timerReload,
    output logic [dataWidth-1:0] timerCount,
    output logic [dataWidth-1:0] timerControl,
    output logic                 timerIrq
);

    logic enable;
    logic irqEnable;
    logic irqFlag;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            timerReload <= '0;
            timerCount  <= '0;
            enable      <= 1'b0;
            irqEnable   <= 1'b0;
            irqFlag     <= 1'b0;
        end else begin
            if (writeEnable && sel.timerReload) begin
                timerReload <= writeData;
            end
            if (writeEnable && sel.timerControl) begin
                enable     <= writeData[0];
                irqEnable  <= writeData[1];
                irqFlag    <= 1'b0; // Any control write acknowledges.
                timerCount <= timerReload; // Restart from reload.
            end else if (enable) begin
                if (timerCount == '1) begin
                    timerCount <= timerReload; // Wrap.
                    if (irqEnable) begin
                        irqFlag <= 1'b1;
                    end
                end else begin
                    timerCount <= timerCount + 1'b1;
                end
            end
        end
    end

    // Flag at bit 2, irqEnable and enable below.
    assign timerControl = {{(dataWidth - 3){1'b0}}, irqFlag, irqEnable, enable};
    assign timerIrq     = irqFlag;

endmodule

//--- decimalSegmentRom.sv
`timescale 1ns/10ps

module decimalSegmentRom import memIoPkg::*; (
    input  logic [wordIndexWidth-1:0] wordIndex,
    output logic [dataWidth-1:0]      segWord
);

    logic [3:0] hundreds;
    logic [3:0] tens;
    logic [3:0] ones;

    // Active-high segments, g down to a.
    function automatic logic [segDigitWidth-1:0] segCode(input logic [3:0] digit);
        logic [segDigitWidth-1:0] code;
        case (digit)
            4'd0:    code = 7'h3F;
            4'd1:    code = 7'h06;
            4'd2:    code = 7'h5B;
            4'd3:    code = 7'h4F;
            4'd4:    code = 7'h66;
            4'd5:    code = 7'h6D;
            4'd6:    code = 7'h7D;
            4'd7:    code = 7'h07;
            4'd8:    code = 7'h7F;
            4'd9:    code = 7'h6F;
            default: code = 7'h00;
        endcase
        return code;
    endfunction

    ////////////////////
    // Decimal split
    ////////////////////
    assign hundreds = 4'(wordIndex / 8'd100);
    assign tens     = 4'((wordIndex / 8'd10) % 8'd10);
    assign ones     = 4'(wordIndex % 8'd10);

    assign segWord = {
        {(dataWidth - segCodeWidth){1'b0}},
        segCode(hundreds), // Top digit.
        segCode(tens),
        segCode(ones)
    };

endmodule

//--- readMux.sv
`timescale 1ns/10ps

module readMux import memIoPkg::*; (
    input  logic                   readEnable,
    input  accessSel_t             sel,
    input  logic [dataWidth-1:0]   ramWord,
    input  logic [dataWidth-1:0]   segWord,
    input  logic [switchWidth-1:0] switchWord,
    input  logic [dataWidth-1:0]   timerReload,
    input  logic [dataWidth-1:0]   timerCount,
    input  logic [dataWidth-1:0]   timerControl,
    output logic [dataWidth-1:0]   readData
);

    always_comb begin
        readData = '0; // Idle and unmapped reads.
        if (readEnable) begin
            if (sel.ram) begin
                readData = ramWord;
            end else if (sel.segTable) begin
                readData = segWord;
            end else if (sel.switchIn) begin
                readData = dataWidth'(switchWord);
            end else if (sel.timerReload) begin
                readData = timerReload;
            end else if (sel.timerCount) begin
                readData = timerCount;
            end else if (sel.timerControl) begin
                readData = timerControl;
            end
        end
    end

endmodule

//--- memIoTop.sv
`timescale 1ns/10ps

module memIoTop import memIoPkg::*; #(
    parameter int ramDepth = 256
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   readEnable,
    input  logic                   writeEnable,
    input  logic [dataWidth-1:0]   address,
    input  logic [dataWidth-1:0]   writeData,
    input  logic [switchWidth-1:0] switch,
    output logic [ledWidth-1:0]    led,
    output logic [tubeWidth-1:0]   tube,
    output logic [dataWidth-1:0]   readData,
    output logic                   timerIrq
);

    accessSel_t             sel;
    logic [dataWidth-1:0]   ramWord;
    logic [dataWidth-1:0]   segWord;
    logic [switchWidth-1:0] switchWord;
    logic [dataWidth-1:0]   timerReload;
    logic [dataWidth-1:0]   timerCount;
    logic [dataWidth-1:0]   timerControl;

    ////////////////////
    // Decode
    ////////////////////
    busDecoder #(
        .ramDepth(ramDepth)
    ) i_busDecoder (
        .address (address),
        .sel     (sel)
    );

    ////////////////////
    // Storage
    ////////////////////
    dataRam #(
        .ramDepth(ramDepth)
    ) i_dataRam (
        .clk         (clk),
        .reset       (reset),
        .writeEnable (writeEnable),
        .sel         (sel),
        .writeData   (writeData),
        .ramWord     (ramWord)
    );

    ioRegisters i_ioRegisters (
        .clk         (clk),
        .reset       (reset),
        .writeEnable (writeEnable),
        .sel         (sel),
        .writeData   (writeData),
        .switch      (switch),
        .led         (led),
        .tube        (tube),
        .switchWord  (switchWord)
    );

    intervalTimer i_intervalTimer (
        .clk          (clk),
        .reset        (reset),
        .writeEnable  (writeEnable),
        .sel          (sel),
        .writeData    (writeData),
        .timerReload  (timerReload),
        .timerCount   (timerCount),
        .timerControl (timerControl),
        .timerIrq     (timerIrq)
    );

    ////////////////////
    // Read path
    ////////////////////
    decimalSegmentRom i_decimalSegmentRom (
        .wordIndex (sel.wordIndex),
        .segWord   (segWord)
    );

    readMux i_readMux (
        .readEnable   (readEnable),
        .sel          (sel),
        .ramWord      (ramWord),
        .segWord      (segWord),
        .switchWord   (switchWord),
        .timerReload  (timerReload),
        .timerCount   (timerCount),
        .timerControl (timerControl),
        .readData     (readData)
    );

endmodule

//--- memIo_checker.sv
`timescale 1ns/10ps

module memIo_checker import memIoPkg::*; (
    input logic                 clk,
    input logic                 reset,
    input logic                 readEnable,
    input logic                 writeEnable,
    input accessSel_t           sel,
    input logic [dataWidth-1:0] readData,
    input logic [ledWidth-1:0]  led,
    input logic                 timerIrq
);

    int failCount = 0;

    idleReadZero: assert property (@(posedge clk) disable iff (reset)
        !readEnable |-> readData == '0)
        else begin
            failCount++;
            $error("readData not zero while readEnable is low");
        end

    // Control write acknowledges the interrupt.
    controlWriteClearsIrq: assert property (@(posedge clk) disable iff (reset)
        (writeEnable && sel.timerControl) |=> !timerIrq)
        else begin
            failCount++;
            $error("timerIrq high after a timerControl write");
        end

    ledHoldsWithoutWrite: assert property (@(posedge clk) disable iff (reset)
        !(writeEnable && sel.led) |=> $stable(led))
        else begin
            failCount++;
            $error("led changed without an LED write");
        end

endmodule

bind memIoTop memIo_checker i_checker (
    .clk         (clk),
    .reset       (reset),
    .readEnable  (readEnable),
    .writeEnable (writeEnable),
    .sel         (sel),
    .readData    (readData),
    .led         (led),
    .timerIrq    (timerIrq)
);

//--- tbClockGen.sv
`timescale 1ns/10ps

module tbClockGen #(
    parameter int halfPeriod  = 2,
    parameter int resetCycles = 3
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #halfPeriod clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (resetCycles) @(posedge clk);
        #1 reset = 1'b0; // Released on the drive point.
    end

endmodule

//--- tbMemIo.sv
`timescale 1ns/10ps

module tbMemIo import memIoPkg::*; ();

    localparam int clkPeriod    = 4;
    localparam int testCycles   = 160; // Reset plus all directed tests.
    localparam int marginCycles = 100;

    logic                   clk;
    logic                   reset;
    logic                   readEnable;
    logic                   writeEnable;
    logic [dataWidth-1:0]   address;
    logic [dataWidth-1:0]   writeData;
    logic [switchWidth-1:0] switch;
    logic [ledWidth-1:0]    led;
    logic [tubeWidth-1:0]   tube;
    logic [dataWidth-1:0]   readData;
    logic                   timerIrq;

    integer               seed;
    int                   checks;
    int                   errors;
    int                   testErrors;
    int                   tests;
    int                   assertFails;
    logic [dataWidth-1:0] model [256]; // Last value written per RAM word.

    tbClockGen i_clockGen (
        .clk   (clk),
        .reset (reset)
    );

    memIoTop #(
        .ramDepth(256)
    ) i_dut (
        .clk         (clk),
        .reset       (reset),
        .readEnable  (readEnable),
        .writeEnable (writeEnable),
        .address     (address),
        .writeData   (writeData),
        .switch      (switch),
        .led         (led),
        .tube        (tube),
        .readData    (readData),
        .timerIrq    (timerIrq)
    );

    ////////////////////
    // Address helpers
    ////////////////////
    function automatic logic [dataWidth-1:0] ramAddr(input logic [7:0] idx);
        busAddr_u a;
        a = '0;
        a.ramView.wordIndex = idx;
        return a;
    endfunction

    function automatic logic [dataWidth-1:0] ioAddr(input logic [15:0] offset);
        busAddr_u a;
        a.ioView.page   = ioPage;
        a.ioView.offset = offset;
        return a;
    endfunction

    function automatic logic [dataWidth-1:0] segAddr(input int n);
        return segWindowBase + 32'(n * 4);
    endfunction

    // Hundreds in the top digit, ones at the bottom.
    function automatic logic [dataWidth-1:0] segExpect(input int n);
        logic [6:0] digitCode [10];
        digitCode = '{7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07, 7'h7F, 7'h6F};
        return {11'b0, digitCode[n / 100], digitCode[(n / 10) % 10], digitCode[n % 10]};
    endfunction

    ////////////////////
    // Bus tasks
    ////////////////////
    task automatic writeWord(input logic [dataWidth-1:0] addr, input logic [dataWidth-1:0] data);
        @(posedge clk);
        #1;
        readEnable  = 1'b0;
        writeEnable = 1'b1; // Commits on the next edge.
        address     = addr;
        writeData   = data;
    endtask

    task automatic readWord(input logic [dataWidth-1:0] addr, output logic [dataWidth-1:0] data);
        @(posedge clk);
        #1;
        writeEnable = 1'b0;
        readEnable  = 1'b1;
        address     = addr;
        #2;
        data = readData;
    endtask

    task automatic idleCycle();
        @(posedge clk);
        #1;
        writeEnable = 1'b0;
        readEnable  = 1'b0;
        #2;
    endtask

    task automatic compare(input string name, input logic [dataWidth-1:0] expected,
                           input logic [dataWidth-1:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            testErrors++;
            $display("mismatch %s expected 0x%h actual 0x%h", name, expected, actual);
        end
    endtask

    task automatic finishTest(input string name);
        $display("test %s done, %0d errors", name, testErrors);
        testErrors = 0;
        tests++;
    endtask

    ////////////////////
    // Directed tests
    ////////////////////
    task automatic ramTest();
        logic [7:0]           idxList [16];
        logic [dataWidth-1:0] data;
        logic [dataWidth-1:0] got;
        foreach (model[i]) model[i] = '0;
        for (int i = 0; i < 20; i++) begin
            readWord(ramAddr(8'($random(seed))), got);
            compare("ram reset", '0, got);
        end
        for (int i = 0; i < 16; i++) begin
            idxList[i] = 8'($random(seed));
            data = $random(seed);
            model[idxList[i]] = data;
            writeWord(ramAddr(idxList[i]), data);
        end
        for (int i = 0; i < 16; i++) begin
            readWord(ramAddr(idxList[i]), got);
            compare("ram write", model[idxList[i]], got);
        end
        finishTest("ram");
    endtask

    task automatic segTest();
        int                   cases [5];
        logic [dataWidth-1:0] got;
        cases = '{0, 7, 42, 199, 255};
        foreach (cases[i]) begin
            readWord(segAddr(cases[i]), got);
            compare("seg lookup", segExpect(cases[i]), got);
        end
        writeWord(segAddr(42), $random(seed)); // Read-only window.
        readWord(segAddr(42), got);
        compare("seg after write", segExpect(42), got);
        readWord(ramAddr(8'd42), got);
        compare("ram under window", model[42], got);
        finishTest("seg");
    endtask

    task automatic ioTest();
        logic [dataWidth-1:0]   data;
        logic [dataWidth-1:0]   got;
        logic [switchWidth-1:0] sw;
        data = $random(seed);
        writeWord(ioAddr(ledOffset), data);
        idleCycle();
        compare("led", 32'(data[ledWidth-1:0]), 32'(led));
        data = $random(seed);
        writeWord(ioAddr(tubeOffset), data);
        idleCycle();
        compare("tube", 32'(data[tubeWidth-1:0]), 32'(tube));
        sw = 8'($random(seed));
        @(posedge clk);
        #1;
        switch = sw;
        readWord(ioAddr(switchOffset), got);
        compare("switch", 32'(sw), got);
        readWord(ioAddr(16'h0018), got);
        compare("unmapped io", '0, got);
        finishTest("io");
    endtask

    task automatic timerCountTest();
        logic [dataWidth-1:0] reload;
        logic [dataWidth-1:0] got;
        reload = 32'hFFFF_FFF0;
        writeWord(ioAddr(timerReloadOffset), reload);
        writeWord(ioAddr(timerControlOffset), 32'h1);
        for (int k = 1; k <= 17; k++) begin
            readWord(ioAddr(timerCountOffset), got);
            compare("timer count", (k <= 16) ? reload + 32'(k - 1) : reload, got);
        end
        writeWord(ioAddr(timerControlOffset), 32'h0);
        idleCycle();
        finishTest("timer count");
    endtask

    task automatic irqTest();
        writeWord(ioAddr(timerReloadOffset), 32'hFFFF_FFF0);
        writeWord(ioAddr(timerControlOffset), 32'h3);
        for (int i = 0; i < 20 && !timerIrq; i++) begin
            idleCycle();
        end
        if (!timerIrq) begin
            errors++;
            testErrors++;
            $display("irq test: timerIrq did not rise within 20 cycles");
        end
        repeat (4) begin
            idleCycle();
            compare("irq sticky", 32'd1, 32'(timerIrq));
        end
        writeWord(ioAddr(timerControlOffset), 32'h1); // Clears flag, irqEnable off.
        idleCycle();
        compare("irq cleared", 32'd0, 32'(timerIrq));
        repeat (20) begin
            idleCycle();
            compare("irq disabled", 32'd0, 32'(timerIrq));
        end
        writeWord(ioAddr(timerControlOffset), 32'h0);
        idleCycle();
        finishTest("irq");
    endtask

    initial begin
        readEnable  = 1'b0;
        writeEnable = 1'b0;
        address     = '0;
        writeData   = '0;
        switch      = '0;
        seed        = 26;
        checks      = 0;
        errors      = 0;
        testErrors  = 0;
        tests       = 0;
        @(negedge reset);
        ramTest();
        segTest();
        ioTest();
        timerCountTest();
        irqTest();
        assertFails = i_dut.i_checker.failCount;
        $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
                 tests, checks, errors, assertFails);
        if (errors == 0 && assertFails == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // Watchdog.
    initial begin
        #((testCycles + marginCycles) * clkPeriod);
        $display("timeout: the tests did not finish in time");
        $display("sim failed");
        $finish;
    end

endmodule

//--- filelist.f
memIoPkg.sv
busDecoder.sv
dataRam.sv
ioRegisters.sv
intervalTimer.sv
decimalSegmentRom.sv
readMux.sv
memIoTop.sv
memIo_checker.sv
tbClockGen.sv
tbMemIo.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tbMemIo -f filelist.f -o simMemIo

./obj_dir/simMemIo +verilator+error+limit+1000 | tee sim.log

if grep -qx "sim passed" sim.log; then
    echo "simulation run ok"
    exit 0
else
    echo "simulation run reported failure"
    exit 1
fi
